//--- common/host_pkg.sv
// Widths, address map and mailbox register offsets shared by every host domain RTL file
package host_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // L2 scratchpad geometry, word interleaved over the banks
  localparam int unsigned NB_L2_BANKS    = 8;
  localparam int unsigned L2_BANK_SIZE   = 1024;
  localparam int unsigned L2_BANK_ADDR_W = $clog2(L2_BANK_SIZE);
  localparam int unsigned L2_BANK_SEL_W  = $clog2(NB_L2_BANKS);

  // Address map
  localparam addr_t L2_BASE   = 32'h1C00_0000;
  localparam addr_t L2_SIZE   = addr_t'(NB_L2_BANKS * L2_BANK_SIZE * 4);
  localparam addr_t MBOX_BASE = 32'h1040_0000;
  localparam addr_t MBOX_SIZE = 32'h0000_1000;

  // Mailbox register offsets inside its window
  localparam addr_t MBOX_DOORBELL_OFS   = 32'h0000_0000;
  localparam addr_t MBOX_COMPLETION_OFS = 32'h0000_0004;

  // Answer for accesses that hit no window
  localparam data_t DEFAULT_RDATA = 32'hDEADF000;

  typedef enum logic [1:0] {
    TGT_L2   = 2'd0,
    TGT_MBOX = 2'd1,
    TGT_NONE = 2'd2
  } target_e;

endpackage

//--- common/host_bus_if.sv
// Fixed-latency request/response bus from the host crossbar to one of its targets
`timescale 1ns/1ps

interface host_bus_if
  import host_pkg::*;
();

  // Request, a single-cycle pulse with the offset inside the target window
  logic  req;
  logic  we;
  addr_t addr;
  data_t wdata;
  strb_t be;

  // Response, valid for exactly one cycle after req
  logic  rvalid;
  data_t rdata;

  modport master (
    output req,
    output we,
    output addr,
    output wdata,
    output be,
    input  rvalid,
    input  rdata
  );

  modport slave (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    input  be,
    output rvalid,
    output rdata
  );

endinterface

//--- l2_subsystem/l2_bank.sv
// Single-port L2 memory bank with byte-enabled writes and a registered read port
`timescale 1ns/1ps

module l2_bank
  import host_pkg::*;
#(
  parameter int unsigned DEPTH = L2_BANK_SIZE,
  parameter int unsigned WIDTH = DATA_W
) (
  input  logic                     clk_i,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [WIDTH/8-1:0]       be_i,
  output logic [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < WIDTH / 8; b++) begin
          if (be_i[b]) begin
            mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end
      // Read returns the old word on a write
      rdata_o <= mem[addr_i];
    end
  end

endmodule

//--- l2_subsystem/l2_subsystem.sv
// L2 scratchpad, word interleaved over NB_L2_BANKS banks behind one bus slave port
`timescale 1ns/1ps

module l2_subsystem
  import host_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  host_bus_if.slave bus
);

  logic [L2_BANK_SEL_W-1:0]  bank_sel;
  logic [L2_BANK_SEL_W-1:0]  bank_sel_q;
  logic [L2_BANK_ADDR_W-1:0] row;
  logic [NB_L2_BANKS-1:0]    bank_en;
  data_t                     bank_rdata [NB_L2_BANKS];
  logic                      rvalid_q;

  // Low word bits pick the bank, the next ones the row
  assign bank_sel = bus.addr[$clog2(STRB_W) +: L2_BANK_SEL_W];
  assign row      = bus.addr[$clog2(STRB_W) + L2_BANK_SEL_W +: L2_BANK_ADDR_W];

  for (genvar i = 0; i < NB_L2_BANKS; i++) begin : gen_bank
    assign bank_en[i] = bus.req && (bank_sel == L2_BANK_SEL_W'(i));

    l2_bank #(
      .DEPTH ( L2_BANK_SIZE ),
      .WIDTH ( DATA_W       )
    ) l2_bank_inst (
      .clk_i   ( clk_i         ),
      .en_i    ( bank_en[i]    ),
      .we_i    ( bus.we        ),
      .addr_i  ( row           ),
      .wdata_i ( bus.wdata     ),
      .be_i    ( bus.be        ),
      .rdata_o ( bank_rdata[i] )
    );
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  // Bank index follows the registered read by one cycle
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      bank_sel_q <= bank_sel;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = bank_rdata[bank_sel_q];

endmodule

//--- rtl/mailbox_regs.sv
// Host to cluster mailbox, doorbell and completion registers that drive the two interrupts
`timescale 1ns/1ps

module mailbox_regs
  import host_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  host_bus_if.slave bus,
  output logic      doorbell_irq_o,
  output logic      completion_irq_o
);

  data_t doorbell_q;
  data_t completion_q;
  data_t rdata_q;
  logic  rvalid_q;
  logic  sel_doorbell;
  logic  sel_completion;

  function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t be);
    data_t res;
    res = old_val;
    for (int b = 0; b < STRB_W; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign sel_doorbell   = (bus.addr == MBOX_DOORBELL_OFS);
  assign sel_completion = (bus.addr == MBOX_COMPLETION_OFS);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      doorbell_q   <= '0;
      completion_q <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      if (bus.req && bus.we) begin
        if (sel_doorbell) begin
          doorbell_q <= merge_bytes(doorbell_q, bus.wdata, bus.be);
        end
        if (sel_completion) begin
          completion_q <= merge_bytes(completion_q, bus.wdata, bus.be);
        end
      end
    end
  end

  // Unknown offsets read as zero
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (sel_doorbell)        rdata_q <= doorbell_q;
      else if (sel_completion) rdata_q <= completion_q;
      else                     rdata_q <= '0;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

  // Any nonzero value holds the interrupt high
  assign doorbell_irq_o   = |doorbell_q;
  assign completion_irq_o = |completion_q;

endmodule

//--- rtl/host_xbar.sv
// Host entry port, decodes each request to L2, mailbox or dummy target and returns one response
`timescale 1ns/1ps

module host_xbar
  import host_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  logic       req_we_i,
  input  addr_t      req_addr_i,
  input  data_t      req_wdata_i,
  input  strb_t      req_be_i,
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,
  output data_t      rsp_rdata_o,
  output logic       rsp_err_o,
  host_bus_if.master l2_bus,
  host_bus_if.master mbox_bus
);

  typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT, ST_RESP} state_e;

  state_e  state_q, state_d;
  target_e tgt_d, tgt_q;
  addr_t   l2_ofs, mbox_ofs, ofs_d;
  addr_t   ofs_q;
  logic    we_q;
  data_t   wdata_q;
  strb_t   be_q;
  data_t   rdata_q;
  logic    err_q;
  logic    accept, rsp_take, tgt_done;

  assign accept   = req_valid_i && req_ready_o;
  assign rsp_take = rsp_valid_o && rsp_ready_i;

  // Unsigned wrap makes one compare per window enough
  assign l2_ofs   = req_addr_i - L2_BASE;
  assign mbox_ofs = req_addr_i - MBOX_BASE;

  always_comb begin
    tgt_d = TGT_NONE;
    ofs_d = req_addr_i;
    if (l2_ofs < L2_SIZE) begin
      tgt_d = TGT_L2;
      ofs_d = l2_ofs;
    end else if (mbox_ofs < MBOX_SIZE) begin
      tgt_d = TGT_MBOX;
      ofs_d = mbox_ofs;
    end
  end

  // Unmapped requests finish without a bus cycle
  assign tgt_done = (tgt_q == TGT_NONE) ||
                    (tgt_q == TGT_L2 && l2_bus.rvalid) ||
                    (tgt_q == TGT_MBOX && mbox_bus.rvalid);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (accept) state_d = ST_ISSUE;
      ST_ISSUE: state_d = ST_WAIT;
      ST_WAIT:  if (tgt_done) state_d = ST_RESP;
      ST_RESP:  if (rsp_take) state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      tgt_q   <= TGT_NONE;
    end else begin
      state_q <= state_d;
      if (accept) tgt_q <= tgt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      ofs_q   <= ofs_d;
      we_q    <= req_we_i;
      wdata_q <= req_wdata_i;
      be_q    <= req_be_i;
    end
    if (state_q == ST_WAIT && tgt_done) begin
      err_q <= (tgt_q == TGT_NONE);
      if (tgt_q == TGT_NONE) rdata_q <= DEFAULT_RDATA;
      else if (we_q)         rdata_q <= '0;
      else if (tgt_q == TGT_L2) rdata_q <= l2_bus.rdata;
      else                   rdata_q <= mbox_bus.rdata;
    end
  end

  assign req_ready_o = (state_q == ST_IDLE);
  assign rsp_valid_o = (state_q == ST_RESP);
  assign rsp_rdata_o = rdata_q;
  assign rsp_err_o   = err_q;

  assign l2_bus.req   = (state_q == ST_ISSUE) && (tgt_q == TGT_L2);
  assign l2_bus.we    = we_q;
  assign l2_bus.addr  = ofs_q;
  assign l2_bus.wdata = wdata_q;
  assign l2_bus.be    = be_q;

  assign mbox_bus.req   = (state_q == ST_ISSUE) && (tgt_q == TGT_MBOX);
  assign mbox_bus.we    = we_q;
  assign mbox_bus.addr  = ofs_q;
  assign mbox_bus.wdata = wdata_q;
  assign mbox_bus.be    = be_q;

endmodule

//--- rtl/host_domain.sv
// Host domain top level, connects the entry crossbar to the L2 scratchpad and the mailbox
`timescale 1ns/1ps

module host_domain
  import host_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,

  // Request channel
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  logic  req_we_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,
  input  strb_t req_be_i,

  // Response channel
  output logic  rsp_valid_o,
  input  logic  rsp_ready_i,
  output data_t rsp_rdata_o,
  output logic  rsp_err_o,

  // Host to cluster interrupts
  output logic  doorbell_irq_o,
  output logic  completion_irq_o
);

  host_bus_if l2_bus ();
  host_bus_if mbox_bus ();

  host_xbar host_xbar_inst (
    .clk_i       ( clk_i           ),
    .rst_n_i     ( rst_n_i         ),
    .req_valid_i ( req_valid_i     ),
    .req_ready_o ( req_ready_o     ),
    .req_we_i    ( req_we_i        ),
    .req_addr_i  ( req_addr_i      ),
    .req_wdata_i ( req_wdata_i     ),
    .req_be_i    ( req_be_i        ),
    .rsp_valid_o ( rsp_valid_o     ),
    .rsp_ready_i ( rsp_ready_i     ),
    .rsp_rdata_o ( rsp_rdata_o     ),
    .rsp_err_o   ( rsp_err_o       ),
    .l2_bus      ( l2_bus.master   ),
    .mbox_bus    ( mbox_bus.master )
  );

  l2_subsystem l2_subsystem_inst (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .bus     ( l2_bus.slave )
  );

  mailbox_regs mailbox_regs_inst (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .bus              ( mbox_bus.slave   ),
    .doorbell_irq_o   ( doorbell_irq_o   ),
    .completion_irq_o ( completion_irq_o )
  );

endmodule

//--- verification/host_domain_assertions.sv
// Handshake checks for the host crossbar, attached to every host_xbar instance by bind
`timescale 1ns/1ps

module host_domain_assertions
  import host_pkg::*;
(
  input logic  clk_i,
  input logic  rst_n_i,
  input logic  rsp_valid_i,
  input logic  rsp_ready_i,
  input data_t rsp_rdata_i,
  input logic  rsp_err_i,
  input logic  l2_req_i,
  input logic  mbox_req_i
);

  int error_count = 0;

  // Pending response holds until taken
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_rdata_i) && $stable(rsp_err_i))
    else begin
      error_count++;
      $error("response changed or dropped before it was taken");
    end

  a_l2_req_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    l2_req_i |=> !l2_req_i)
    else begin
      error_count++;
      $error("L2 bus req high in two consecutive cycles");
    end

  a_mbox_req_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mbox_req_i |=> !mbox_req_i)
    else begin
      error_count++;
      $error("mailbox bus req high in two consecutive cycles");
    end

endmodule

bind host_xbar host_domain_assertions host_domain_assertions_inst (
  .clk_i       ( clk_i        ),
  .rst_n_i     ( rst_n_i      ),
  .rsp_valid_i ( rsp_valid_o  ),
  .rsp_ready_i ( rsp_ready_i  ),
  .rsp_rdata_i ( rsp_rdata_o  ),
  .rsp_err_i   ( rsp_err_o    ),
  .l2_req_i    ( l2_bus.req   ),
  .mbox_req_i  ( mbox_bus.req )
);

//--- verification/tb_host_domain.sv
// Testbench for host_domain that replays the test data transactions and checks each response
`timescale 1ns/1ps

module tb_host_domain
  import host_pkg::*;
();

  logic  clk_i;
  logic  rst_n_i;
  logic  req_valid_i;
  logic  req_ready_o;
  logic  req_we_i;
  addr_t req_addr_i;
  data_t req_wdata_i;
  strb_t req_be_i;
  logic  rsp_valid_o;
  logic  rsp_ready_i;
  data_t rsp_rdata_o;
  logic  rsp_err_o;
  logic  doorbell_irq_o;
  logic  completion_irq_o;

  // One entry per transaction line
  string names[$];
  logic  we_list[$];
  addr_t addr_list[$];
  data_t wdata_list[$];
  strb_t be_list[$];
  data_t exp_rdata[$];
  logic  exp_err[$];
  logic  exp_db[$];
  logic  exp_cmp[$];

  integer seed;
  int     num_tests;
  int     pass_count;
  int     fail_count;
  int     other_errors;
  bit     loaded;

  host_domain host_domain_inst (.*);

  always #5 clk_i = ~clk_i;

  task automatic load_tests();
    int    fd;
    int    n;
    string line;
    string name;
    string op;
    data_t addr, wdata, be, rdata, err, db, cmp;
    fd = $fopen("verification/host_domain_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/host_domain_testdata.txt");
      other_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h %h %h %h %h",
                      name, op, addr, wdata, be, rdata, err, db, cmp);
          if (n == 9) begin
            names.push_back(name);
            we_list.push_back(op == "wr");
            addr_list.push_back(addr);
            wdata_list.push_back(wdata);
            be_list.push_back(be[STRB_W-1:0]);
            exp_rdata.push_back(rdata);
            exp_err.push_back(err[0]);
            exp_db.push_back(db[0]);
            exp_cmp.push_back(cmp[0]);
          end
        end
      end
      $fclose(fd);
    end
    num_tests = names.size();
  endtask

  // New random response ready on each falling edge and the busy check
  task automatic next_cycle();
    data_t rnd;
    @(negedge clk_i);
    rnd = $random(seed);
    rsp_ready_i = rnd[0];
    if (rsp_valid_o && req_ready_o) begin
      $display("req_ready_o is high while a response is pending");
      other_errors++;
    end
  endtask

  function automatic bit check_value(string test, string field, data_t expv, data_t actv);
    if (expv !== actv) begin
      $display("mismatch %s %s: expected %h, actual %h", test, field, expv, actv);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic run_test(int i);
    bit    ok;
    bit    taken;
    int    wait_cycles;
    data_t got_rdata;
    logic  got_err, got_db, got_cmp;
    ok = 1'b1;
    taken = 1'b0;
    wait_cycles = 0;
    next_cycle();
    req_we_i    = we_list[i];
    req_addr_i  = addr_list[i];
    req_wdata_i = wdata_list[i];
    req_be_i    = be_list[i];
    req_valid_i = 1'b1;
    while (!req_ready_o) next_cycle();
    // Accepted at the rising edge inside this step
    next_cycle();
    req_valid_i = 1'b0;
    // Response is due two cycles after acceptance
    while (!rsp_valid_o) begin
      wait_cycles++;
      next_cycle();
    end
    ok &= check_value(names[i], "latency", data_t'(2), data_t'(wait_cycles));
    while (!taken) begin
      if (rsp_valid_o && rsp_ready_i) begin
        got_rdata = rsp_rdata_o;
        got_err   = rsp_err_o;
        got_db    = doorbell_irq_o;
        got_cmp   = completion_irq_o;
        taken     = 1'b1;
      end
      next_cycle();
    end
    if (rsp_valid_o || !req_ready_o) begin
      $display("%s: response still valid or request port not ready after the take", names[i]);
      ok = 1'b0;
    end
    ok &= check_value(names[i], "rdata", exp_rdata[i], got_rdata);
    ok &= check_value(names[i], "err", data_t'(exp_err[i]), data_t'(got_err));
    ok &= check_value(names[i], "doorbell_irq", data_t'(exp_db[i]), data_t'(got_db));
    ok &= check_value(names[i], "completion_irq", data_t'(exp_cmp[i]), data_t'(got_cmp));
    if (ok) pass_count++;
    else    fail_count++;
    $display("%s %s", names[i], ok ? "passed" : "failed");
  endtask

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_we_i = 1'b0;
    req_addr_i = '0;
    req_wdata_i = '0;
    req_be_i = '0;
    rsp_ready_i = 1'b0;
    seed = 32'h8c50f906;
    pass_count = 0;
    fail_count = 0;
    other_errors = 0;
    load_tests();
    loaded = 1'b1;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    if (!req_ready_o || rsp_valid_o || doorbell_irq_o || completion_irq_o) begin
      $display("outputs do not hold their reset values after reset");
      other_errors++;
    end
    for (int i = 0; i < num_tests; i++) run_test(i);
    if (host_domain_inst.host_xbar_inst.host_domain_assertions_inst.error_count != 0) begin
      $display("handshake assertions failed during the run");
      other_errors++;
    end
    $display("tests: %0d passed, %0d failed, %0d other errors",
             pass_count, fail_count, other_errors);
    if (fail_count == 0 && other_errors == 0 && num_tests > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog allows 40 cycles per transaction on top of the reset
  initial begin
    wait (loaded);
    #((num_tests * 40 + 16) * 10);
    $display("timeout: the transactions did not finish in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- verification/host_domain_testdata.txt
# Columns: name op(wr/rd) addr wdata be expected_rdata expected_err expected_doorbell expected_completion
# Numbers in hex; a write answers read data 0, or DEADF000 with err 1 when unmapped
bank0_wr wr 1C000000 10000001 f 00000000 0 0 0
bank1_wr wr 1C000004 20000002 f 00000000 0 0 0
bank2_wr wr 1C000008 30000003 f 00000000 0 0 0
bank3_wr wr 1C00000C 40000004 f 00000000 0 0 0
bank4_wr wr 1C000010 50000005 f 00000000 0 0 0
bank5_wr wr 1C000014 60000006 f 00000000 0 0 0
bank6_wr wr 1C000018 70000007 f 00000000 0 0 0
bank7_wr wr 1C00001C 80000008 f 00000000 0 0 0
l2_top_wr wr 1C007FFC A5A5A5A5 f 00000000 0 0 0
part_be_wr wr 1C000004 1234BEEF 3 00000000 0 0 0
bank0_rd rd 1C000000 00000000 0 10000001 0 0 0
bank1_rd rd 1C000004 00000000 0 2000BEEF 0 0 0
bank2_rd rd 1C000008 00000000 0 30000003 0 0 0
bank3_rd rd 1C00000C 00000000 0 40000004 0 0 0
bank4_rd rd 1C000010 00000000 0 50000005 0 0 0
bank5_rd rd 1C000014 00000000 0 60000006 0 0 0
bank6_rd rd 1C000018 00000000 0 70000007 0 0 0
bank7_rd rd 1C00001C 00000000 0 80000008 0 0 0
l2_top_rd rd 1C007FFC 00000000 0 A5A5A5A5 0 0 0
db_set wr 10400000 00000001 f 00000000 0 1 0
db_rd rd 10400000 00000000 0 00000001 0 1 0
cmp_set wr 10400004 CAFE0000 f 00000000 0 1 1
cmp_rd rd 10400004 00000000 0 CAFE0000 0 1 1
unmapped_rd rd 00000000 00000000 0 DEADF000 1 1 1
unmapped_wr_mbox wr 10401000 FFFFFFFF f DEADF000 1 1 1
unmapped_wr_l2 wr 1C008000 FFFFFFFF f DEADF000 1 1 1
db_keep_rd rd 10400000 00000000 0 00000001 0 1 1
l2_keep_rd rd 1C000000 00000000 0 10000001 0 1 1
db_clr wr 10400000 00000000 f 00000000 0 0 1
cmp_clr wr 10400004 00000000 f 00000000 0 0 0
cmp_clr_rd rd 10400004 00000000 0 00000000 0 0 0

//--- flist.f
common/host_pkg.sv
common/host_bus_if.sv
l2_subsystem/l2_bank.sv
l2_subsystem/l2_subsystem.sv
rtl/mailbox_regs.sv
rtl/host_xbar.sv
rtl/host_domain.sv
verification/host_domain_assertions.sv
verification/tb_host_domain.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f flist.f --top-module tb_host_domain -o sim_tb || exit 1
out=$(./obj_dir/sim_tb +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS" && exit 0 || exit 1
